// File: build.f
src/video_pkg.sv
src/overlay_pkg.sv
src/dvi_capture.sv
src/frame_measure.sv
src/test_pattern_feeder.sv
src/overlay_mixer.sv
src/seg7_display.sv
src/video_overlay_top.sv
tests/overlay_checker.sv
tests/tb_video_overlay.sv

// File: tests/tb_video_overlay.sv
/*
 * Video overlay testbench
 * Plays a table of frames through the overlay engine with random
 * pixels and external words; the checker does the comparing.
 */
`timescale 1ns/1ps

module tb_video_overlay;

  import video_pkg::*;
  import overlay_pkg::*;

  localparam int NUM_ROWS   = 7;
  localparam int WAIT_LIMIT = 16;

  // One frame of stimulus with its expected dimensions
  typedef struct packed {
    logic [15:0] w;
    logic [15:0] h;
    logic [7:0]  blank;
    logic        sel;
    logic        en;
    logic        pause;
    logic [15:0] exp_w;
    logic [15:0] exp_h;
  } frame_row_t;

  frame_row_t rows [NUM_ROWS];

  logic                     clk_i;
  logic                     reset_i;
  logic                     vid_vsync_i;
  logic                     vid_hsync_i;
  logic                     vid_de_i;
  rgb_t                     vid_pix_i;
  ovl_word_t                ext_word_i;
  logic                     ext_empty_i;
  ovl_src_e                 src_sel_i;
  logic                     overlay_en_i;
  logic                     pause_i;
  logic                     ovl_rd_o;
  logic                     vga_vsync_o;
  logic                     vga_hsync_o;
  logic                     vga_blank_n_o;
  rgb_t                     vga_pix_o;
  logic [15:0]              width_o;
  logic [15:0]              height_o;
  seg_t [SEG_DIGITS-1:0]    hex_o;
  logic                     dim_chk;
  logic [15:0]              exp_w;
  logic [15:0]              exp_h;
  logic [31:0]              rng;
  logic                     timed_out;
  int                       sync_errs;
  int                       pix_errs;
  int                       rd_errs;
  int                       dim_errs;
  int                       hex_errs;

  video_overlay_top video_overlay_top_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .vid_vsync_i (vid_vsync_i), .vid_hsync_i (vid_hsync_i),
    .vid_de_i (vid_de_i), .vid_pix_i (vid_pix_i),
    .ext_word_i (ext_word_i), .ext_empty_i (ext_empty_i),
    .src_sel_i (src_sel_i), .overlay_en_i (overlay_en_i), .pause_i (pause_i),
    .ovl_rd_o (ovl_rd_o), .vga_vsync_o (vga_vsync_o), .vga_hsync_o (vga_hsync_o),
    .vga_blank_n_o (vga_blank_n_o), .vga_pix_o (vga_pix_o),
    .width_o (width_o), .height_o (height_o), .hex_o (hex_o)
  );

  overlay_checker checker_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .vid_vsync_i (vid_vsync_i), .vid_hsync_i (vid_hsync_i),
    .vid_de_i (vid_de_i), .vid_pix_i (vid_pix_i),
    .ext_word_i (ext_word_i), .ext_empty_i (ext_empty_i),
    .src_sel_i (src_sel_i), .overlay_en_i (overlay_en_i), .pause_i (pause_i),
    .ovl_rd_i (ovl_rd_o), .vga_vsync_i (vga_vsync_o), .vga_hsync_i (vga_hsync_o),
    .vga_blank_n_i (vga_blank_n_o), .vga_pix_i (vga_pix_o),
    .width_i (width_o), .height_i (height_o), .hex_i (hex_o),
    .dim_chk_i (dim_chk), .exp_w_i (exp_w), .exp_h_i (exp_h),
    .sync_errs_o (sync_errs), .pix_errs_o (pix_errs), .rd_errs_o (rd_errs),
    .dim_errs_o (dim_errs), .hex_errs_o (hex_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One pixel clock of raw video with fresh random colour and word
  task automatic drive_cycle(input logic vs, input logic hs, input logic de);
    @(posedge clk_i);
    #1;
    vid_vsync_i = vs;
    vid_hsync_i = hs;
    vid_de_i    = de;
    rng         = xorshift32(rng);
    vid_pix_i   = rng[23:0];
    rng         = xorshift32(rng);
    ext_word_i  = rng[24:0];
    ext_empty_i = rng[31];
    dim_chk     = 1'b0;
  endtask

  task automatic wait_vga_vsync();
    int n;
    n = 0;
    while (vga_vsync_o !== 1'b1 && n < WAIT_LIMIT) begin
      drive_cycle(1'b1, 1'b0, 1'b0);
      n++;
    end
    if (vga_vsync_o !== 1'b1) begin
      $display("Timeout: VGA vsync did not rise within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  // ====================
  // Frame player
  // ====================
  task automatic play_frame(input frame_row_t row);
    src_sel_i    = ovl_src_e'(row.sel);
    overlay_en_i = row.en;
    pause_i      = row.pause;
    for (int l = 0; l < row.h; l++) begin
      for (int p = 0; p < row.w; p++)
        drive_cycle(1'b0, 1'b0, 1'b1);
      // Short hsync pulse at the start of blanking
      for (int b = 0; b < row.blank; b++)
        drive_cycle(1'b0, b < 2, 1'b0);
    end
    // Closing vsync publishes this frame's size
    drive_cycle(1'b1, 1'b0, 1'b0);
    wait_vga_vsync();
    if (!timed_out) begin
      exp_w   = row.exp_w;
      exp_h   = row.exp_h;
      dim_chk = 1'b1;
      for (int b = 0; b < row.blank; b++)
        drive_cycle(1'b0, 1'b0, 1'b0);
    end
  endtask

  initial begin
    rng          = 32'h9bab49a4;
    timed_out    = 1'b0;
    reset_i      = 1'b1;
    vid_vsync_i  = 1'b0;
    vid_hsync_i  = 1'b0;
    vid_de_i     = 1'b0;
    vid_pix_i    = '0;
    ext_word_i   = '0;
    ext_empty_i  = 1'b1;
    src_sel_i    = OVL_SRC_EXT;
    overlay_en_i = 1'b0;
    pause_i      = 1'b0;
    dim_chk      = 1'b0;
    exp_w        = '0;
    exp_h        = '0;

    // w, h, blank, sel, en, pause, expected w, expected h
    rows[0] = '{16'd12, 16'd4, 8'd4, 1'b0, 1'b0, 1'b0, 16'd12, 16'd4};
    rows[1] = '{16'd20, 16'd6, 8'd5, 1'b0, 1'b1, 1'b0, 16'd20, 16'd6};
    rows[2] = '{16'd16, 16'd5, 8'd3, 1'b1, 1'b1, 1'b0, 16'd16, 16'd5};
    rows[3] = '{16'd18, 16'd3, 8'd4, 1'b1, 1'b1, 1'b1, 16'd18, 16'd3};
    // No active lines so the previous size stays
    rows[4] = '{16'd9, 16'd0, 8'd6, 1'b1, 1'b1, 1'b0, 16'd18, 16'd3};
    rows[5] = '{16'd300, 16'd2, 8'd8, 1'b0, 1'b1, 1'b0, 16'd300, 16'd2};
    rows[6] = '{16'd7, 16'd33, 8'd4, 1'b1, 1'b0, 1'b0, 16'd7, 16'd33};

    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Idle after reset with size still zero
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0);
    exp_w   = '0;
    exp_h   = '0;
    dim_chk = 1'b1;
    drive_cycle(1'b0, 1'b0, 1'b0);

    for (int r = 0; r < NUM_ROWS && !timed_out; r++)
      play_frame(rows[r]);
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0);

    $display("Errors: sync %0d, pixel %0d, read strobe %0d, dimension %0d, display %0d",
             sync_errs, pix_errs, rd_errs, dim_errs, hex_errs);
    if (!timed_out && sync_errs + pix_errs + rd_errs + dim_errs + hex_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: tests/overlay_checker.sv
/*
 * Overlay checker
 * Watches the overlay engine ports, models capture, mixing and the
 * feeder counter, and compares VGA output, read strobe and dimensions.
 */
`timescale 1ns/1ps

module overlay_checker (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            vid_vsync_i,
  input  logic                                            vid_hsync_i,
  input  logic                                            vid_de_i,
  input  video_pkg::rgb_t                                 vid_pix_i,
  input  overlay_pkg::ovl_word_t                          ext_word_i,
  input  logic                                            ext_empty_i,
  input  overlay_pkg::ovl_src_e                           src_sel_i,
  input  logic                                            overlay_en_i,
  input  logic                                            pause_i,
  input  logic                                            ovl_rd_i,
  input  logic                                            vga_vsync_i,
  input  logic                                            vga_hsync_i,
  input  logic                                            vga_blank_n_i,
  input  video_pkg::rgb_t                                 vga_pix_i,
  input  logic [15:0]                                     width_i,
  input  logic [15:0]                                     height_i,
  input  overlay_pkg::seg_t [overlay_pkg::SEG_DIGITS-1:0] hex_i,
  input  logic                                            dim_chk_i,
  input  logic [15:0]                                     exp_w_i,
  input  logic [15:0]                                     exp_h_i,
  output int                                              sync_errs_o,
  output int                                              pix_errs_o,
  output int                                              rd_errs_o,
  output int                                              dim_errs_o,
  output int                                              hex_errs_o
);

  import video_pkg::*;
  import overlay_pkg::*;

  // Standard active low digits, gfedcba, digit F down to 0
  localparam logic [16*7-1:0] SEG_TABLE = {
    7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
    7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
  };

  video_bus_t  cap_m;
  video_bus_t  out_m;
  logic [23:0] cnt_m;
  ovl_word_t   word_m;
  logic        sel_test;
  logic        sel_empty;
  logic        take;
  rgb_t        mix;
  logic [31:0] dims;
  seg_t        exp_seg;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  initial begin
    sync_errs_o = 0;
    pix_errs_o  = 0;
    rd_errs_o   = 0;
    dim_errs_o  = 0;
    hex_errs_o  = 0;
  end

  // ====================
  // Pixel path model
  // ====================
  always @(negedge clk_i) begin
    if (reset_i) begin
      cap_m = '0;
      out_m = '0;
      cnt_m = '0;
    end else begin
      // Outputs now show what was mixed one cycle ago
      if ({vga_vsync_i, vga_hsync_i, vga_blank_n_i} !== {out_m.vsync, out_m.hsync, out_m.de}) begin
        sync_errs_o++;
        report_mismatch("vga_vsync_o/vga_hsync_o/vga_blank_n_o",
                        {vga_vsync_i, vga_hsync_i, vga_blank_n_i},
                        {out_m.vsync, out_m.hsync, out_m.de});
      end
      if (vga_pix_i !== out_m.pix) begin
        pix_errs_o++;
        report_mismatch("vga_pix_o", vga_pix_i, out_m.pix);
      end

      sel_test = (src_sel_i == OVL_SRC_TEST);
      if (sel_test)
        word_m = {cnt_m[0], cnt_m};
      else
        word_m = ext_word_i;
      sel_empty = sel_test ? pause_i : ext_empty_i;
      take      = cap_m.de & overlay_en_i & ~sel_empty;

      if (ovl_rd_i !== (take & ~sel_test)) begin
        rd_errs_o++;
        report_mismatch("ovl_rd_o", ovl_rd_i, take & ~sel_test);
      end

      if (!cap_m.de)
        mix = '0;
      else if (take && word_m.opaque)
        mix = word_m.color;
      else
        mix = cap_m.pix;

      out_m = '{vsync: cap_m.vsync, hsync: cap_m.hsync, de: cap_m.de, pix: mix};
      if (take && sel_test)
        cnt_m = cnt_m + 1'b1;
      cap_m = '{vsync: vid_vsync_i, hsync: vid_hsync_i, de: vid_de_i, pix: vid_pix_i};
    end
  end

  // ====================
  // Dimensions and display
  // ====================
  always @(negedge clk_i) begin
    if (!reset_i && dim_chk_i) begin
      if (width_i !== exp_w_i) begin
        dim_errs_o++;
        report_mismatch("width_o", width_i, exp_w_i);
      end
      if (height_i !== exp_h_i) begin
        dim_errs_o++;
        report_mismatch("height_o", height_i, exp_h_i);
      end
      // Width on the upper four digits
      dims = {exp_w_i, exp_h_i};
      for (int i = 0; i < SEG_DIGITS; i++) begin
        exp_seg = SEG_TABLE[7*dims[4*i +: 4] +: 7];
        if (hex_i[i] !== exp_seg) begin
          hex_errs_o++;
          report_mismatch($sformatf("hex_o[%0d]", i), hex_i[i], exp_seg);
        end
      end
    end
  end

endmodule

// File: src/video_overlay_top.sv
/*
 * Video overlay engine
 * DVI capture, frame measurement, overlay sources, mixer and the
 * dimension readout, all on the DVI pixel clock.
 */
`timescale 1ns/1ps

module video_overlay_top #(
  parameter int DIM_W = video_pkg::DIM_W_DEFAULT
) (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            vid_vsync_i,
  input  logic                                            vid_hsync_i,
  input  logic                                            vid_de_i,
  input  video_pkg::rgb_t                                 vid_pix_i,
  input  overlay_pkg::ovl_word_t                          ext_word_i,
  input  logic                                            ext_empty_i,
  input  overlay_pkg::ovl_src_e                           src_sel_i,
  input  logic                                            overlay_en_i,
  input  logic                                            pause_i,
  output logic                                            ovl_rd_o,
  output logic                                            vga_vsync_o,
  output logic                                            vga_hsync_o,
  output logic                                            vga_blank_n_o,
  output video_pkg::rgb_t                                 vga_pix_o,
  output logic [DIM_W-1:0]                                width_o,
  output logic [DIM_W-1:0]                                height_o,
  output overlay_pkg::seg_t [overlay_pkg::SEG_DIGITS-1:0] hex_o
);

  import video_pkg::*;
  import overlay_pkg::*;

  video_bus_t cap_bus;
  video_bus_t out_bus;
  ovl_word_t  test_word;
  logic       test_empty;
  logic       test_rd;

  dvi_capture dvi_capture_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .vid_vsync_i (vid_vsync_i),
    .vid_hsync_i (vid_hsync_i),
    .vid_de_i    (vid_de_i),
    .vid_pix_i   (vid_pix_i),
    .cap_bus_o   (cap_bus)
  );

  frame_measure #(
    .DIM_W (DIM_W)
  ) frame_measure_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cap_bus_i (cap_bus),
    .width_o   (width_o),
    .height_o  (height_o)
  );

  test_pattern_feeder test_pattern_feeder_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .pause_i (pause_i),
    .rd_i    (test_rd),
    .word_o  (test_word),
    .empty_o (test_empty)
  );

  overlay_mixer overlay_mixer_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cap_bus_i    (cap_bus),
    .src_sel_i    (src_sel_i),
    .overlay_en_i (overlay_en_i),
    .ext_word_i   (ext_word_i),
    .ext_empty_i  (ext_empty_i),
    .test_word_i  (test_word),
    .test_empty_i (test_empty),
    .ext_rd_o     (ovl_rd_o),
    .test_rd_o    (test_rd),
    .out_bus_o    (out_bus)
  );

  // Display shows the low 16 bits of each dimension
  seg7_display seg7_display_i (
    .width_i  (width_o[15:0]),
    .height_i (height_o[15:0]),
    .hex_o    (hex_o)
  );

  assign vga_vsync_o   = out_bus.vsync;
  assign vga_hsync_o   = out_bus.hsync;
  assign vga_blank_n_o = out_bus.de;
  assign vga_pix_o     = out_bus.pix;

endmodule

// File: src/seg7_display.sv
/*
 * Seven-segment display
 * Shows width and height as eight hex digits, width on the upper four.
 */
`timescale 1ns/1ps

module seg7_display (
  input  logic [15:0]                                     width_i,
  input  logic [15:0]                                     height_i,
  output overlay_pkg::seg_t [overlay_pkg::SEG_DIGITS-1:0] hex_o
);

  import overlay_pkg::*;

  logic [4*SEG_DIGITS-1:0] digits;

  // Active low, gfedcba
  function automatic seg_t hex2seg(input logic [3:0] nib);
    case (nib)
      4'h0:    hex2seg = 7'b1000000;
      4'h1:    hex2seg = 7'b1111001;
      4'h2:    hex2seg = 7'b0100100;
      4'h3:    hex2seg = 7'b0110000;
      4'h4:    hex2seg = 7'b0011001;
      4'h5:    hex2seg = 7'b0010010;
      4'h6:    hex2seg = 7'b0000010;
      4'h7:    hex2seg = 7'b1111000;
      4'h8:    hex2seg = 7'b0000000;
      4'h9:    hex2seg = 7'b0010000;
      4'ha:    hex2seg = 7'b0001000;
      4'hb:    hex2seg = 7'b0000011;
      4'hc:    hex2seg = 7'b1000110;
      4'hd:    hex2seg = 7'b0100001;
      4'he:    hex2seg = 7'b0000110;
      default: hex2seg = 7'b0001110;
    endcase
  endfunction

  // Leftmost digit gets the top nibble of the width
  assign digits = {width_i, height_i};

  always_comb begin
    for (int i = 0; i < SEG_DIGITS; i++) begin
      hex_o[i] = hex2seg(digits[4*i +: 4]);
    end
  end

endmodule

// File: src/overlay_mixer.sv
/*
 * Overlay mixer
 * Picks the overlay source, pulls one word per active pixel when
 * available and keys opaque words over the captured video.
 */
`timescale 1ns/1ps

module overlay_mixer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  video_pkg::video_bus_t  cap_bus_i,
  input  overlay_pkg::ovl_src_e  src_sel_i,
  input  logic                   overlay_en_i,
  input  overlay_pkg::ovl_word_t ext_word_i,
  input  logic                   ext_empty_i,
  input  overlay_pkg::ovl_word_t test_word_i,
  input  logic                   test_empty_i,
  output logic                   ext_rd_o,
  output logic                   test_rd_o,
  output video_pkg::video_bus_t  out_bus_o
);

  import video_pkg::*;
  import overlay_pkg::*;

  logic      sel_test;
  ovl_word_t sel_word;
  logic      sel_empty;
  logic      take;
  rgb_t      mix_pix;
  logic      vsync_q;
  logic      hsync_q;
  logic      de_q;
  rgb_t      pix_q;

  // ====================
  // Source select
  // ====================
  assign sel_test  = (src_sel_i == OVL_SRC_TEST);
  assign sel_word  = sel_test ? test_word_i : ext_word_i;
  assign sel_empty = sel_test ? test_empty_i : ext_empty_i;

  // Consume the shown word for this pixel
  assign take      = cap_bus_i.de & overlay_en_i & ~sel_empty;
  assign ext_rd_o  = take & ~sel_test;
  assign test_rd_o = take & sel_test;

  // ====================
  // Keying
  // ====================
  always_comb begin
    if (!cap_bus_i.de)
      mix_pix = '0;
    else if (take && sel_word.opaque)
      mix_pix = sel_word.color;
    else
      mix_pix = cap_bus_i.pix;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vsync_q <= 1'b0;
      hsync_q <= 1'b0;
      de_q    <= 1'b0;
    end else begin
      vsync_q <= cap_bus_i.vsync;
      hsync_q <= cap_bus_i.hsync;
      de_q    <= cap_bus_i.de;
    end
  end

  always_ff @(posedge clk_i) begin
    pix_q <= mix_pix;
  end

  assign out_bus_o = '{vsync: vsync_q, hsync: hsync_q, de: de_q, pix: pix_q};

endmodule

// File: src/test_pattern_feeder.sv
/*
 * Test pattern feeder
 * Internal overlay source. Shows a running counter as the colour,
 * with every odd count opaque. Holds off while paused.
 */
`timescale 1ns/1ps

module test_pattern_feeder (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  pause_i,
  input  logic                  rd_i,
  output overlay_pkg::ovl_word_t word_o,
  output logic                  empty_o
);

  import video_pkg::*;

  // One count per colour bit
  localparam int CNT_W = 3 * COLOR_W;

  logic [CNT_W-1:0] cnt_q;

  // Advance once per consumed word
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (rd_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign word_o = '{opaque: cnt_q[0], color: rgb_t'(cnt_q)};

  // Paused feeder looks like a drained source
  assign empty_o = pause_i;

endmodule

// File: src/frame_measure.sv
/*
 * Frame measurement
 * Counts active pixels per line and active lines per frame, and
 * publishes both at the start of the next vsync pulse.
 */
`timescale 1ns/1ps

module frame_measure #(
  parameter int DIM_W = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  video_pkg::video_bus_t cap_bus_i,
  output logic [DIM_W-1:0]      width_o,
  output logic [DIM_W-1:0]      height_o
);

  logic             de_d;
  logic             vsync_d;
  logic [DIM_W-1:0] pix_cnt;
  logic [DIM_W-1:0] line_cnt;
  logic [DIM_W-1:0] line_width;
  logic             de_fall;
  logic             vsync_rise;

  assign de_fall    = de_d & ~cap_bus_i.de;
  assign vsync_rise = cap_bus_i.vsync & ~vsync_d;

  // ====================
  // Line measurement
  // ====================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      de_d    <= 1'b0;
      vsync_d <= 1'b0;
      pix_cnt <= '0;
    end else begin
      de_d    <= cap_bus_i.de;
      vsync_d <= cap_bus_i.vsync;
      // Restarts in every blanking gap
      if (cap_bus_i.de)
        pix_cnt <= pix_cnt + 1'b1;
      else
        pix_cnt <= '0;
    end
  end

  // Width of the most recent active line
  always_ff @(posedge clk_i) begin
    if (de_fall)
      line_width <= pix_cnt;
  end

  // ====================
  // Frame measurement
  // ====================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      line_cnt <= '0;
      width_o  <= '0;
      height_o <= '0;
    end else if (vsync_rise) begin
      // Frames without active video keep the old result
      if (line_cnt != '0) begin
        width_o  <= line_width;
        height_o <= line_cnt;
      end
      line_cnt <= '0;
    end else if (de_fall) begin
      line_cnt <= line_cnt + 1'b1;
    end
  end

endmodule

// File: src/dvi_capture.sv
/*
 * DVI capture
 * Input register stage for the DVI receiver pins, bundled into one bus.
 */
`timescale 1ns/1ps

module dvi_capture (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  vid_vsync_i,
  input  logic                  vid_hsync_i,
  input  logic                  vid_de_i,
  input  video_pkg::rgb_t       vid_pix_i,
  output video_pkg::video_bus_t cap_bus_o
);

  import video_pkg::*;

  logic vsync_q;
  logic hsync_q;
  logic de_q;
  rgb_t pix_q;

  // Sync and enable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vsync_q <= 1'b0;
      hsync_q <= 1'b0;
      de_q    <= 1'b0;
    end else begin
      vsync_q <= vid_vsync_i;
      hsync_q <= vid_hsync_i;
      de_q    <= vid_de_i;
    end
  end

  // Pixel data
  always_ff @(posedge clk_i) begin
    pix_q <= vid_pix_i;
  end

  assign cap_bus_o = '{vsync: vsync_q, hsync: hsync_q, de: de_q, pix: pix_q};

endmodule

// File: src/overlay_pkg.sv
/*
 * Overlay types
 * Overlay word layout, overlay source selection and the
 * seven-segment display definitions.
 */
package overlay_pkg;

  // Colour plus keying flag
  typedef struct packed {
    logic              opaque;
    video_pkg::rgb_t   color;
  } ovl_word_t;

  typedef enum logic {
    OVL_SRC_EXT  = 1'b0,
    OVL_SRC_TEST = 1'b1
  } ovl_src_e;

  // Hex digits on the board
  localparam int SEG_DIGITS = 8;

  // Active low, segment a in bit 0
  typedef logic [6:0] seg_t;

endpackage

// File: src/video_pkg.sv
/*
 * Video types
 * Pixel colour and captured video bus definitions, plus the default
 * width of the frame dimension counters.
 */
package video_pkg;

  // Bits per colour channel
  localparam int COLOR_W = 8;

  // Width and height counters
  localparam int DIM_W_DEFAULT = 16;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  // One pixel clock worth of video
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t pix;
  } video_bus_t;

endpackage
